// File: common/exec_cfg.svh
// Configuration macros for the execute subsystem
// Word width, register file size and buffer depths
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Data word width
`define EXEC_DATA_W 16

// Register file size and address width
`define EXEC_REGS 16
`define EXEC_REG_AW $clog2(`EXEC_REGS)

// Buffer depths and the downstream credits granted after reset
`define EXEC_IN_DEPTH 4
`define EXEC_OUT_DEPTH 4
`define EXEC_OUT_CREDITS 2

`endif

// File: common/exec_pkg.sv
// Shared types for the execute subsystem
// Opcodes, ALU operations, flag classes, branch conditions, retire item
`default_nettype none
`include "exec_cfg.svh"

package exec_pkg;

	// Raw instruction word, payload of the input buffer
	typedef logic [`EXEC_DATA_W-1:0] instr_t;

	typedef enum logic [3:0] {
		op_add  = 4'h0,
		op_addz = 4'h1,
		op_sub  = 4'h2,
		op_and  = 4'h3,
		op_nor  = 4'h4,
		op_sll  = 4'h5,
		op_srl  = 4'h6,
		op_sra  = 4'h7,
		op_lw   = 4'h8,
		op_sw   = 4'h9,
		op_lhb  = 4'ha,
		op_llb  = 4'hb,
		op_b    = 4'hc,
		op_jal  = 4'hd,
		op_jr   = 4'he,
		op_hlt  = 4'hf
	} opcode_e;

	typedef enum logic [2:0] {
		alu_add = 3'b000,
		alu_sub = 3'b001,
		alu_and = 3'b010,
		alu_nor = 3'b011,
		alu_sll = 3'b100,
		alu_srl = 3'b101,
		alu_lhb = 3'b110,
		alu_sra = 3'b111
	} alu_op_e;

	typedef enum logic [1:0] {
		fc_nzv,
		fc_z_only,
		fc_none
	} flag_class_e;

	// How the ALU stage treats the instruction
	typedef enum logic [2:0] {
		oc_alu,
		oc_addz,
		oc_lhb,
		oc_llb,
		oc_branch,
		oc_nop
	} op_class_e;

	typedef enum logic [2:0] {
		br_ne     = 3'b000,
		br_eq     = 3'b001,
		br_gt     = 3'b010,
		br_lt     = 3'b011,
		br_ge     = 3'b100,
		br_le     = 3'b101,
		br_ovf    = 3'b110,
		br_always = 3'b111
	} br_cond_e;

	typedef struct packed {
		logic n;
		logic z;
		logic v;
	} flags_t;

	// Payload of the output buffer
	typedef struct packed {
		logic [`EXEC_REG_AW-1:0] rd;
		logic [`EXEC_DATA_W-1:0] data;
		logic                    wr;
		logic                    taken;
		flags_t                  flags;
	} retire_t;

endpackage

`default_nettype wire

// File: common/exec_if.sv
// Decoded instruction bundle from decode to the ALU stage
`timescale 1ns/1ps
`default_nettype none
`include "exec_cfg.svh"

interface exec_if;
	import exec_pkg::*;

	logic                    valid;
	alu_op_e                 op;
	flag_class_e             fclass;
	op_class_e               oclass;
	logic [`EXEC_REG_AW-1:0] rd;
	// Register file read addresses, rt holds rd for lhb
	logic [`EXEC_REG_AW-1:0] rs;
	logic [`EXEC_REG_AW-1:0] rt;
	logic [3:0]              shamt;
	logic [7:0]              imm8;
	br_cond_e                cond;

	modport decoder (output valid, op, fclass, oclass, rd, rs, rt, shamt, imm8, cond);

	// Read addresses go straight to the register file
	modport alu (input valid, op, fclass, oclass, rd, shamt, imm8, cond);

endinterface

`default_nettype wire

// File: design/credit_fifo.sv
// Circular buffer with credit-gated pop and credit return on pop
`timescale 1ns/1ps
`default_nettype none

module credit_fifo #(
	parameter int  DEPTH        = 4,
	parameter int  INIT_CREDITS = 0,
	parameter type T            = logic [15:0]
) (
	input  wire  clk,
	input  wire  rst_n,
	input  wire  push,
	input  wire  T push_data,
	output logic credit_ret,
	output logic pop_valid,
	output T     pop_data,
	input  wire  credit_in
);

	localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	// Headroom above the initial count for early credit returns
	localparam int CRD_W = $clog2(DEPTH + INIT_CREDITS + 1) + 1;

	T mem [DEPTH];

	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CRD_W-1:0] credits;
	logic             pop;

	// Pop needs an item and a free slot downstream
	assign pop = (count != '0) && (credits != '0);

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr] <= push_data;
		end
		if (pop) begin
			pop_data <= mem[rd_ptr];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			count      <= '0;
			credits    <= CRD_W'(INIT_CREDITS);
			pop_valid  <= 1'b0;
			credit_ret <= 1'b0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
			case ({credit_in, pop})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
			pop_valid  <= pop;
			credit_ret <= pop;
		end
	end

endmodule

`default_nettype wire

// File: design/instr_decode.sv
// Instruction decoder, field split and opcode classification
// Result is registered onto the exec_if bundle
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
	input wire      clk,
	input wire      rst_n,
	input wire      instr_valid,
	input wire      exec_pkg::instr_t instr,
	exec_if.decoder dec
);
	import exec_pkg::*;

	opcode_e     opcode;
	alu_op_e     op_d;
	flag_class_e fclass_d;
	op_class_e   oclass_d;
	logic [3:0]  rt_d;

	assign opcode = opcode_e'(instr[15:12]);

	always_comb begin
		op_d     = alu_add;
		fclass_d = fc_none;
		oclass_d = oc_nop;
		rt_d     = instr[3:0];
		case (opcode)
			op_add: begin
				fclass_d = fc_nzv;
				oclass_d = oc_alu;
			end
			op_addz: begin
				fclass_d = fc_nzv;
				oclass_d = oc_addz;
			end
			op_sub: begin
				op_d     = alu_sub;
				fclass_d = fc_nzv;
				oclass_d = oc_alu;
			end
			op_and: begin
				op_d     = alu_and;
				fclass_d = fc_z_only;
				oclass_d = oc_alu;
			end
			op_nor: begin
				op_d     = alu_nor;
				fclass_d = fc_z_only;
				oclass_d = oc_alu;
			end
			op_sll: begin
				op_d     = alu_sll;
				fclass_d = fc_z_only;
				oclass_d = oc_alu;
			end
			op_srl: begin
				op_d     = alu_srl;
				fclass_d = fc_z_only;
				oclass_d = oc_alu;
			end
			op_sra: begin
				op_d     = alu_sra;
				fclass_d = fc_z_only;
				oclass_d = oc_alu;
			end
			op_lhb: begin
				// Old low byte of rd comes in on the second read port
				op_d     = alu_lhb;
				oclass_d = oc_lhb;
				rt_d     = instr[11:8];
			end
			op_llb:  oclass_d = oc_llb;
			op_b:    oclass_d = oc_branch;
			// Memory, jumps and halt retire as no-ops
			default: oclass_d = oc_nop;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec.valid <= 1'b0;
		end else begin
			dec.valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec.op     <= op_d;
			dec.fclass <= fclass_d;
			dec.oclass <= oclass_d;
			dec.rd     <= instr[11:8];
			dec.rs     <= instr[7:4];
			dec.rt     <= rt_d;
			dec.shamt  <= instr[3:0];
			dec.imm8   <= instr[7:0];
			dec.cond   <= br_cond_e'(instr[11:9]);
		end
	end

endmodule

`default_nettype wire

// File: design/reg_file.sv
// Register file with two asynchronous reads and one synchronous write
`timescale 1ns/1ps
`default_nettype none
`include "exec_cfg.svh"

module reg_file (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire [`EXEC_REG_AW-1:0]  rd_addr_a,
	input  wire [`EXEC_REG_AW-1:0]  rd_addr_b,
	output logic [`EXEC_DATA_W-1:0] rd_data_a,
	output logic [`EXEC_DATA_W-1:0] rd_data_b,
	input  wire                     wr_en,
	input  wire [`EXEC_REG_AW-1:0]  wr_addr,
	input  wire [`EXEC_DATA_W-1:0]  wr_data
);

	logic [`EXEC_DATA_W-1:0] regs [`EXEC_REGS];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `EXEC_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en && (wr_addr != '0)) begin
			// Writes to register 0 are dropped
			regs[wr_addr] <= wr_data;
		end
	end

	// Register 0 always reads as zero
	assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
	assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];

endmodule

`default_nettype wire

// File: alu/alu_core.sv
// ALU stage with saturating arithmetic, logic, shifts and byte loads
// Flag registers, branch evaluation, write-back and retire item
`timescale 1ns/1ps
`default_nettype none
`include "exec_cfg.svh"

module alu_core (
	input  wire                     clk,
	input  wire                     rst_n,
	exec_if.alu                     dec,
	input  wire [`EXEC_DATA_W-1:0]  src_a,
	input  wire [`EXEC_DATA_W-1:0]  src_b,
	output logic                    wr_en,
	output logic [`EXEC_REG_AW-1:0] wr_addr,
	output logic [`EXEC_DATA_W-1:0] wr_data,
	output logic                    retire_valid,
	output exec_pkg::retire_t       retire
);
	import exec_pkg::*;

	localparam int W = `EXEC_DATA_W;

	logic [W-1:0] b_eff;
	logic [W-1:0] sum;
	logic [W-1:0] alu_out;
	logic [W-1:0] result;
	logic         is_sub;
	logic         ov_pos;
	logic         ov_neg;
	logic         do_write;
	logic         cond_true;
	flags_t       flags_q;
	flags_t       flags_d;

	// Subtract as a + ~b + 1 so one overflow check covers both
	assign is_sub = (dec.op == alu_sub);
	assign b_eff  = is_sub ? ~src_b : src_b;
	assign sum    = src_a + b_eff + W'(is_sub);
	assign ov_pos = ~src_a[W-1] & ~b_eff[W-1] & sum[W-1];
	assign ov_neg = src_a[W-1] & b_eff[W-1] & ~sum[W-1];

	always_comb begin
		case (dec.op)
			alu_add, alu_sub: begin
				if (ov_pos) begin
					alu_out = {1'b0, {(W-1){1'b1}}};
				end else if (ov_neg) begin
					alu_out = {1'b1, {(W-1){1'b0}}};
				end else begin
					alu_out = sum;
				end
			end
			alu_and: alu_out = src_a & src_b;
			alu_nor: alu_out = ~(src_a | src_b);
			alu_sll: alu_out = src_a << dec.shamt;
			alu_srl: alu_out = src_a >> dec.shamt;
			alu_sra: alu_out = $signed(src_a) >>> dec.shamt;
			alu_lhb: alu_out = {dec.imm8, src_b[W-9:0]};
			default: alu_out = '0;
		endcase
	end

	// llb bypasses the ALU with the sign-extended immediate
	assign result = (dec.oclass == oc_llb) ? {{(W-8){dec.imm8[7]}}, dec.imm8} : alu_out;

	// addz only executes when Z is already set
	assign do_write = dec.valid && (dec.oclass != oc_branch) && (dec.oclass != oc_nop) &&
		((dec.oclass != oc_addz) || flags_q.z);

	always_comb begin
		flags_d = flags_q;
		if (do_write) begin
			case (dec.fclass)
				fc_nzv: begin
					flags_d.n = result[W-1];
					flags_d.z = (result == '0);
					flags_d.v = ov_pos | ov_neg;
				end
				fc_z_only: flags_d.z = (result == '0);
				default:   flags_d = flags_q;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			flags_q <= '0;
		end else begin
			flags_q <= flags_d;
		end
	end

	// Branch conditions test the flags held before the branch
	always_comb begin
		case (dec.cond)
			br_ne:     cond_true = ~flags_q.z;
			br_eq:     cond_true = flags_q.z;
			br_gt:     cond_true = ~flags_q.z & ~flags_q.n;
			br_lt:     cond_true = flags_q.n;
			br_ge:     cond_true = flags_q.z | ~flags_q.n;
			br_le:     cond_true = flags_q.n | flags_q.z;
			br_ovf:    cond_true = flags_q.v;
			default:   cond_true = 1'b1;
		endcase
	end

	assign wr_en   = do_write;
	assign wr_addr = dec.rd;
	assign wr_data = result;

	// Every valid instruction retires, no-ops carry zero data
	assign retire_valid = dec.valid;
	assign retire.rd    = dec.rd;
	assign retire.data  = do_write ? result : '0;
	assign retire.wr    = do_write;
	assign retire.taken = dec.valid && (dec.oclass == oc_branch) && cond_true;
	assign retire.flags = flags_d;

endmodule

`default_nettype wire

// File: design/exec_top.sv
// Execute subsystem top level
// Input buffer, decode, register file, ALU stage and output buffer
`timescale 1ns/1ps
`default_nettype none
`include "exec_cfg.svh"

module exec_top (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     in_valid,
	input  wire [`EXEC_DATA_W-1:0]  in_instr,
	output logic                    in_credit,
	output logic                    out_valid,
	output logic [`EXEC_REG_AW-1:0] out_rd,
	output logic [`EXEC_DATA_W-1:0] out_data,
	output logic                    out_wr,
	output logic                    out_taken,
	output logic                    out_n,
	output logic                    out_z,
	output logic                    out_v,
	input  wire                     out_credit
);
	import exec_pkg::*;

	instr_t                  fetch_instr;
	logic                    fetch_valid;
	logic [`EXEC_DATA_W-1:0] rf_data_a;
	logic [`EXEC_DATA_W-1:0] rf_data_b;
	logic                    wb_en;
	logic [`EXEC_REG_AW-1:0] wb_addr;
	logic [`EXEC_DATA_W-1:0] wb_data;
	logic                    ret_valid;
	retire_t                 ret_item;
	retire_t                 out_item;
	logic                    out_slot_free;

	exec_if ex_if ();

	// Input buffer pops only against free output buffer slots
	credit_fifo #(
		.DEPTH        (`EXEC_IN_DEPTH),
		.INIT_CREDITS (`EXEC_OUT_DEPTH),
		.T            (instr_t)
	) in_fifo_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (in_valid),
		.push_data  (in_instr),
		.credit_ret (in_credit),
		.pop_valid  (fetch_valid),
		.pop_data   (fetch_instr),
		.credit_in  (out_slot_free)
	);

	instr_decode decode_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_valid (fetch_valid),
		.instr       (fetch_instr),
		.dec         (ex_if.decoder)
	);

	reg_file rf_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_addr_a (ex_if.rs),
		.rd_addr_b (ex_if.rt),
		.rd_data_a (rf_data_a),
		.rd_data_b (rf_data_b),
		.wr_en     (wb_en),
		.wr_addr   (wb_addr),
		.wr_data   (wb_data)
	);

	alu_core alu_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.dec          (ex_if.alu),
		.src_a        (rf_data_a),
		.src_b        (rf_data_b),
		.wr_en        (wb_en),
		.wr_addr      (wb_addr),
		.wr_data      (wb_data),
		.retire_valid (ret_valid),
		.retire       (ret_item)
	);

	// Downstream grants all its credits through out_credit
	credit_fifo #(
		.DEPTH        (`EXEC_OUT_DEPTH),
		.INIT_CREDITS (0),
		.T            (retire_t)
	) out_fifo_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.push       (ret_valid),
		.push_data  (ret_item),
		.credit_ret (out_slot_free),
		.pop_valid  (out_valid),
		.pop_data   (out_item),
		.credit_in  (out_credit)
	);

	assign out_rd    = out_item.rd;
	assign out_data  = out_item.data;
	assign out_wr    = out_item.wr;
	assign out_taken = out_item.taken;
	assign out_n     = out_item.flags.n;
	assign out_z     = out_item.flags.z;
	assign out_v     = out_item.flags.v;

endmodule

`default_nettype wire

// File: bench/exec_tb.sv
// Testbench for the execute subsystem
// Instruction table with reference model, credit handling and in-order checks
`timescale 1ns/1ps
`default_nettype none
`include "exec_cfg.svh"

module exec_tb;
	import exec_pkg::*;

	localparam int N_DIR       = 46;
	localparam int N_RAND      = 24;
	localparam int N_ROWS      = N_DIR + N_RAND;
	localparam int CYCLE_LIMIT = 20 * N_ROWS + 100;

	// Directed rows ahead of the random ones
	localparam logic [15:0] DIRECTED [N_DIR] = '{
		// Constants built with llb then lhb
		16'hB134, 16'hA112, 16'hB2FF, 16'hA27F, 16'hB301, 16'hB400, 16'hA480, 16'hB5FF,
		// Saturating add and sub and a sub of equal values
		16'h0623, 16'h2743, 16'h2811, 16'h0915, 16'h2A32, 16'h0B45,
		// Logic and shifts
		16'h3C15, 16'h4D55, 16'h5E14, 16'h6E4F, 16'h7E4F, 16'h7F13,
		// All branch conditions with N, V set and Z clear
		16'hC000, 16'hC200, 16'hC400, 16'hC600, 16'hC800, 16'hCA00, 16'hCC00, 16'hCE00,
		// Sub sets Z before all branch conditions again
		16'h2811,
		16'hC000, 16'hC200, 16'hC400, 16'hC600, 16'hC800, 16'hCA00, 16'hCC00, 16'hCE00,
		// addz with Z set and again with Z clear
		16'h1933, 16'h1933, 16'hC400, 16'hC800,
		// Memory, jumps and halt retire as no-ops
		16'h8123, 16'h9123, 16'hD123, 16'hE123, 16'hF000
	};

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [15:0] in_instr;
	logic        in_credit;
	logic        out_valid;
	logic [3:0]  out_rd;
	logic [15:0] out_data;
	logic        out_wr;
	logic        out_taken;
	logic        out_n;
	logic        out_z;
	logic        out_v;
	logic        out_credit;

	logic [15:0] instr_tab [N_ROWS];
	logic [3:0]  exp_rd [N_ROWS];
	logic [15:0] exp_data [N_ROWS];
	logic        exp_wr [N_ROWS];
	logic        exp_taken [N_ROWS];
	logic [2:0]  exp_flags [N_ROWS];

	// Model state with flags ordered n z v
	logic [15:0] m_regs [16];
	logic [2:0]  m_flags;
	logic [31:0] rng;
	logic        started;
	int          issued;
	int          up_credits;
	int          credit_pulses;
	int          pending_credits;
	int          received;
	int          passes;
	int          errors;
	int          cycles;

	exec_top dut_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_instr   (in_instr),
		.in_credit  (in_credit),
		.out_valid  (out_valid),
		.out_rd     (out_rd),
		.out_data   (out_data),
		.out_wr     (out_wr),
		.out_taken  (out_taken),
		.out_n      (out_n),
		.out_z      (out_z),
		.out_v      (out_v),
		.out_credit (out_credit)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Applies one row to the model and records the expected retire item
	task automatic model_row(input int i);
		logic [15:0] ins;
		logic [3:0]  rd;
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] res;
		logic        wr;
		logic        taken;
		logic        n;
		logic        z;
		logic        v;
		int          s;
		ins   = instr_tab[i];
		rd    = ins[11:8];
		a     = m_regs[ins[7:4]];
		b     = m_regs[ins[3:0]];
		res   = '0;
		wr    = 1'b0;
		taken = 1'b0;
		{n, z, v} = m_flags;
		case (ins[15:12])
			op_add, op_addz, op_sub: begin
				if ((ins[15:12] != op_addz) || z) begin
					if (ins[15:12] == op_sub) begin
						s = int'($signed(a)) - int'($signed(b));
					end else begin
						s = int'($signed(a)) + int'($signed(b));
					end
					v = (s > 32767) || (s < -32768);
					if (s > 32767) begin
						res = 16'h7fff;
					end else if (s < -32768) begin
						res = 16'h8000;
					end else begin
						res = 16'(s);
					end
					n  = res[15];
					z  = (res == 16'h0);
					wr = 1'b1;
				end
			end
			op_and, op_nor, op_sll, op_srl, op_sra: begin
				case (ins[15:12])
					op_and:  res = a & b;
					op_nor:  res = ~(a | b);
					op_sll:  res = a << ins[3:0];
					op_srl:  res = a >> ins[3:0];
					default: res = $signed(a) >>> ins[3:0];
				endcase
				z  = (res == 16'h0);
				wr = 1'b1;
			end
			op_lhb: begin
				res = {ins[7:0], m_regs[rd][7:0]};
				wr  = 1'b1;
			end
			op_llb: begin
				res = {{8{ins[7]}}, ins[7:0]};
				wr  = 1'b1;
			end
			op_b: begin
				case (ins[11:9])
					3'd0:    taken = !z;
					3'd1:    taken = z;
					3'd2:    taken = !z && !n;
					3'd3:    taken = n;
					3'd4:    taken = z || !n;
					3'd5:    taken = n || z;
					3'd6:    taken = v;
					default: taken = 1'b1;
				endcase
			end
			default: ;
		endcase
		if (wr && (rd != 4'h0)) begin
			m_regs[rd] = res;
		end
		m_flags      = {n, z, v};
		exp_rd[i]    = rd;
		exp_data[i]  = res;
		exp_wr[i]    = wr;
		exp_taken[i] = taken;
		exp_flags[i] = m_flags;
	endtask

	// Compares the current output item against its table row
	task automatic check_output(input int row);
		assert ((out_rd == exp_rd[row]) && (out_data == exp_data[row]) &&
			(out_wr == exp_wr[row]) && (out_taken == exp_taken[row]) &&
			({out_n, out_z, out_v} == exp_flags[row])) begin
			passes++;
			$display("Row %0d instr %h ok", row, instr_tab[row]);
		end else begin
			$write("CHECK FAILED at %0t: row %0d instr %h", $time, row, instr_tab[row]);
			$write(" got rd %h data %h wr %b taken %b nzv %b", out_rd, out_data, out_wr,
				out_taken, {out_n, out_z, out_v});
			$display(", expected rd %h data %h wr %b taken %b nzv %b", exp_rd[row],
				exp_data[row], exp_wr[row], exp_taken[row], exp_flags[row]);
			errors++;
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		started         = 1'b0;
		rst_n           = 1'b0;
		in_valid        = 1'b0;
		in_instr        = '0;
		out_credit      = 1'b0;
		rng             = 32'd35;
		issued          = 0;
		up_credits      = `EXEC_IN_DEPTH;
		credit_pulses   = 0;
		pending_credits = `EXEC_OUT_CREDITS;
		received        = 0;
		passes          = 0;
		errors          = 0;
		cycles          = 0;
		m_flags         = '0;
		for (int r = 0; r < 16; r++) begin
			m_regs[r] = '0;
		end
		for (int i = 0; i < N_ROWS; i++) begin
			if (i < N_DIR) begin
				instr_tab[i] = DIRECTED[i];
			end else begin
				rng          = xorshift(rng);
				instr_tab[i] = rng[15:0];
			end
			model_row(i);
		end
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// Bench processes all start at the following falling edge
		@(posedge clk);
		started = 1'b1;
		wait (received == N_ROWS);
		// A few more cycles catch any extra output item
		repeat (10) @(negedge clk);
		$display("%0d rows checked, %0d passed, %0d errors", received, passes, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Upstream side pushes once per held credit
	always @(negedge clk) begin
		if (started) begin
			if (in_credit) begin
				up_credits++;
				credit_pulses++;
				assert (credit_pulses <= issued) else begin
					$display("CHECK FAILED at %0t: %0d credit returns for %0d instructions",
						$time, credit_pulses, issued);
					errors++;
				end
			end
			if ((issued < N_ROWS) && (up_credits > 0)) begin
				in_valid = 1'b1;
				in_instr = instr_tab[issued];
				issued++;
				up_credits--;
			end else begin
				in_valid = 1'b0;
			end
		end
	end

	// Downstream side returns credits after random delays
	always @(negedge clk) begin
		if (started) begin
			if (out_valid) begin
				pending_credits++;
			end
			rng = xorshift(rng);
			if ((pending_credits > 0) && (rng[1:0] != 2'b00)) begin
				out_credit = 1'b1;
				pending_credits--;
			end else begin
				out_credit = 1'b0;
			end
		end
	end

	always @(negedge clk) begin
		if (started && out_valid) begin
			if (received >= N_ROWS) begin
				$display("Extra output item at %0t after all rows retired", $time);
				errors++;
			end else begin
				check_output(received);
				received++;
			end
		end
	end

	always @(posedge clk) begin
		if (started) begin
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Run stopped after %0d cycles with only %0d of %0d items retired",
					cycles, received, N_ROWS);
				$display("Result: FAILED");
				$finish;
			end
		end
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/exec_pkg.sv
common/exec_if.sv
design/credit_fifo.sv
design/instr_decode.sv
design/reg_file.sv
alu/alu_core.sv
design/exec_top.sv
bench/exec_tb.sv

// File: Bender.yml
package:
  name: exec_subsystem

sources:
  - include_dirs:
      - common
    files:
      - common/exec_pkg.sv
      - common/exec_if.sv
      - design/credit_fifo.sv
      - design/instr_decode.sv
      - design/reg_file.sv
      - alu/alu_core.sv
      - design/exec_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/exec_tb.sv
